/* acc_management.f */
src/acc_pkg.sv
src/conf_loader.sv
src/read_engine.sv
src/req_arbiter.sv
src/acc_management.sv
tb/acc_checker.sv
tb/tb_acc_management.sv

/* tb/tb_acc_management.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_acc_management;

  localparam logic [31:0] SEED  = 32'h29bf_26c3;
  localparam int          SLOTS = 16;

  logic                             clk = 1'b0;
  logic                             rst_n;
  logic                             conf_valid;
  acc_pkg::conf_t                   conf;
  logic [acc_pkg::NUM_ENGINES-1:0]  start_accs;
  logic [acc_pkg::NUM_ENGINES-1:0]  rst_accs;
  logic                             req_rd_available = 1'b1;
  logic                             req_rd_en;
  acc_pkg::rd_req_t                 req_rd_req;
  logic                             resp_rd_valid = 1'b0;
  acc_pkg::rd_resp_t                resp_rd = '0;
  acc_pkg::engine_status_t          status [acc_pkg::NUM_ENGINES];

  logic              test_done;
  int                test_num;
  logic              run_end;
  int                error_count;
  logic              timed_out;
  logic              avail_random = 1'b0;
  logic              model_overflow = 1'b0;
  int                mem_busy = 0;
  logic [31:0]       stim_rng = SEED;
  logic [31:0]       mem_rng = SEED;
  logic              slot_valid [SLOTS];
  int                slot_wait  [SLOTS];
  acc_pkg::rd_resp_t slot_resp  [SLOTS];

  always #5 clk = ~clk;

  acc_management u_acc_management (
    .clk              (clk),
    .rst_n            (rst_n),
    .conf_valid       (conf_valid),
    .conf             (conf),
    .start_accs       (start_accs),
    .rst_accs         (rst_accs),
    .req_rd_available (req_rd_available),
    .req_rd_en        (req_rd_en),
    .req_rd_req       (req_rd_req),
    .resp_rd_valid    (resp_rd_valid),
    .resp_rd          (resp_rd),
    .status           (status)
  );

  acc_checker u_acc_checker (
    .clk              (clk),
    .rst_n            (rst_n),
    .conf_valid       (conf_valid),
    .conf             (conf),
    .start_accs       (start_accs),
    .rst_accs         (rst_accs),
    .req_rd_available (req_rd_available),
    .req_rd_en        (req_rd_en),
    .req_rd_req       (req_rd_req),
    .status           (status),
    .test_done        (test_done),
    .test_num         (test_num),
    .run_end          (run_end),
    .error_count      (error_count),
    .timed_out        (timed_out)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // ==================================================
  // Memory model
  // ==================================================

  // Responses wait 1 to 8 cycles in a slot, one leaves per cycle.
  always @(posedge clk) begin : mem_model
    int pick;
    int free;
    int busy;
    pick = -1;
    free = -1;
    busy = 0;
    for (int s = 0; s < SLOTS; s++) begin
      if (!rst_n) slot_valid[s] = 1'b0;
      if (slot_valid[s] && slot_wait[s] == 0 && pick < 0) pick = s;
    end
    if (pick >= 0) begin
      resp_rd_valid <= 1'b1;
      resp_rd       <= slot_resp[pick];
      slot_valid[pick] = 1'b0;
    end else begin
      resp_rd_valid <= 1'b0;
    end
    for (int s = 0; s < SLOTS; s++) begin
      if (slot_valid[s] && slot_wait[s] != 0) slot_wait[s]--;
      if (!slot_valid[s] && free < 0) free = s;
    end
    if (req_rd_en) begin
      mem_rng = xorshift32(mem_rng);
      if (free < 0) begin
        $display("Memory model has no free slot for a read request");
        model_overflow <= 1'b1;
      end else begin
        slot_valid[free]      = 1'b1;
        slot_wait[free]       = int'(mem_rng[2:0]);
        slot_resp[free].data  = 32'(req_rd_req.addr) ^ 32'h5a5a_0000;
        slot_resp[free].mdata = req_rd_req.mdata;   // Tag echoed back.
      end
    end
    if (avail_random) begin
      mem_rng = xorshift32(mem_rng);
      req_rd_available <= mem_rng[7];
    end else begin
      req_rd_available <= 1'b1;
    end
    for (int s = 0; s < SLOTS; s++) busy += slot_valid[s];
    mem_busy <= busy;
  end

  // ==================================================
  // Stimulus
  // ==================================================

  task automatic configure(input logic [1:0] id, input logic [15:0] base, input logic [7:0] cnt);
    conf_valid <= 1'b1;
    conf       <= {id, base, cnt};
    @(posedge clk);
    conf_valid <= 1'b0;
  endtask

  task automatic configure_random(input logic [1:0] id, input int min_cnt, input int span);
    logic [7:0] cnt;
    stim_rng = xorshift32(stim_rng);
    cnt = 8'(min_cnt + int'(stim_rng[7:0]) % span);
    configure(id, stim_rng[31:16], cnt);
  endtask

  task automatic start_engines(input logic [3:0] mask);
    start_accs <= mask;
    @(posedge clk);
    start_accs <= '0;
  endtask

  task automatic wait_done(input logic [3:0] mask);
    logic [3:0] done_bits;
    done_bits = '0;
    repeat (3) @(posedge clk);   // Old done bits clear first.
    while ((done_bits & mask) != mask) begin
      @(posedge clk);
      for (int i = 0; i < acc_pkg::NUM_ENGINES; i++) done_bits[i] = status[i].done;
    end
  endtask

  task automatic wait_mem_idle();
    repeat (2) @(posedge clk);
    while (mem_busy != 0 || req_rd_en) @(posedge clk);
    repeat (2) @(posedge clk);
  endtask

  task automatic finish_test(input int n);
    test_num  <= n;
    test_done <= 1'b1;
    @(posedge clk);
    test_done <= 1'b0;
  endtask

  always @(posedge clk) begin
    if (timed_out) begin
      $display("Checks failed");
      $finish;
    end
  end

  initial begin
    rst_n      = 1'b0;
    conf_valid = 1'b0;
    conf       = '0;
    start_accs = '0;
    rst_accs   = '0;
    test_done  = 1'b0;
    test_num   = 0;
    run_end    = 1'b0;
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);

    configure(2'd0, 16'h0100, 8'd16);
    start_engines(4'b0001);
    wait_done(4'b0001);
    finish_test(1);

    for (int i = 0; i < 4; i++) configure_random(2'(i), 8, 33);
    start_engines(4'b1111);
    wait_done(4'b1111);
    finish_test(2);

    avail_random <= 1'b1;
    for (int i = 0; i < 4; i++) configure_random(2'(i), 10, 40);
    start_engines(4'b1111);
    wait_done(4'b1111);
    avail_random <= 1'b0;
    finish_test(3);

    // Staggered starts.
    for (int i = 0; i < 4; i++) configure_random(2'(i), 5, 30);
    start_engines(4'b0100);
    repeat (3) @(posedge clk);
    start_engines(4'b0001);
    repeat (5) @(posedge clk);
    start_engines(4'b1010);
    wait_done(4'b1111);
    finish_test(4);

    configure(2'd1, 16'h4000, 8'd200);
    start_engines(4'b0010);
    repeat (40) @(posedge clk);
    rst_accs <= 4'b0010;   // Abort in the middle of the run.
    @(posedge clk);
    rst_accs <= '0;
    wait_mem_idle();
    start_engines(4'b0010);
    wait_done(4'b0010);
    finish_test(5);

    avail_random <= 1'b1;
    for (int i = 0; i < 4; i++) configure_random(2'(i), 40, 60);
    start_engines(4'b1111);
    wait_done(4'b1111);
    avail_random <= 1'b0;
    finish_test(6);

    run_end <= 1'b1;
    @(posedge clk);
    run_end <= 1'b0;
    repeat (2) @(posedge clk);
    if (error_count == 0 && !model_overflow && !timed_out) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* tb/acc_checker.sv */
`timescale 1ns/10ps
`default_nettype none

module acc_checker (
  input  logic                              clk,
  input  logic                              rst_n,
  input  logic                              conf_valid,
  input  acc_pkg::conf_t                    conf,
  input  logic [acc_pkg::NUM_ENGINES-1:0]   start_accs,
  input  logic [acc_pkg::NUM_ENGINES-1:0]   rst_accs,
  input  logic                              req_rd_available,
  input  logic                              req_rd_en,
  input  acc_pkg::rd_req_t                  req_rd_req,
  input  acc_pkg::engine_status_t           status [acc_pkg::NUM_ENGINES],
  input  logic                              test_done,
  input  int                                test_num,
  input  logic                              run_end,
  output int                                error_count,
  output logic                              timed_out
);

  logic [acc_pkg::ADDR_W-1:0]       cfg_base  [acc_pkg::NUM_ENGINES];
  logic [acc_pkg::COUNT_W-1:0]      cfg_count [acc_pkg::NUM_ENGINES];
  int                               issued    [acc_pkg::NUM_ENGINES];
  logic [acc_pkg::NUM_ENGINES-1:0]  prev_done;
  logic [acc_pkg::NUM_ENGINES-1:0]  prev_rst;
  logic                             prev_avail;
  int                               cycles;
  int                               total_words;
  int                               errs = 0;
  int                               checks = 0;
  int                               tests = 0;
  int                               test_base = 0;

  // Memory word at addr is {16'h0, addr} ^ 32'h5a5a_0000.
  function automatic logic [acc_pkg::SUM_W-1:0] expected_sum(input logic [15:0] base,
                                                             input logic [7:0]  count);
    logic [acc_pkg::SUM_W-1:0] acc;
    logic [15:0]               addr;
    acc = '0;
    for (int i = 0; i < int'(count); i++) begin
      addr = base + 16'(i);
      acc  = acc + (32'(addr) ^ 32'h5a5a_0000);
    end
    return acc;
  endfunction

  always @(posedge clk) begin : compare
    logic [acc_pkg::ENGINE_ID_W-1:0] tag;
    logic [acc_pkg::ADDR_W-1:0]      offset;
    logic [acc_pkg::MDATA_W-1:0]     exp_mdata;
    logic [acc_pkg::SUM_W-1:0]       expected;
    if (!rst_n) begin
      prev_done   = '0;
      prev_rst    = '0;
      prev_avail  = 1'b0;
      cycles      = 0;
      total_words = 0;
      timed_out  <= 1'b0;
      for (int i = 0; i < acc_pkg::NUM_ENGINES; i++) issued[i] = 0;
    end else begin
      cycles++;
      if (!timed_out && cycles > 20 * total_words + 500) begin
        $display("Timeout, the run did not end within %0d cycles", cycles);
        timed_out <= 1'b1;
      end
      if (conf_valid) begin
        cfg_base[conf.engine_id]  = conf.base;
        cfg_count[conf.engine_id] = conf.count;
        total_words += int'(conf.count);
      end

      // ==================================================
      // Read port
      // ==================================================
      if (req_rd_en) begin
        tag       = req_rd_req.mdata[acc_pkg::MDATA_W-1 -: acc_pkg::ENGINE_ID_W];
        offset    = req_rd_req.addr - cfg_base[tag];   // Wraps like the engine.
        exp_mdata = {tag, {acc_pkg::TAG_PAD_W{1'b0}}, offset[acc_pkg::COUNT_W-1:0]};
        issued[tag]++;
        checks += 3;
        if (offset >= cfg_count[tag]) begin
          $display("FAILED req_rd_req.addr: %h outside range of engine %0d",
                   req_rd_req.addr, tag);
          errs++;
        end
        if (req_rd_req.mdata != exp_mdata) begin
          $display("FAILED req_rd_req.mdata: got %h expected %h",
                   req_rd_req.mdata, exp_mdata);
          errs++;
        end
        if (!prev_avail) begin
          $display("Read request issued while req_rd_available was low the cycle before");
          errs++;
        end
      end

      // ==================================================
      // Engine results
      // ==================================================
      for (int i = 0; i < acc_pkg::NUM_ENGINES; i++) begin
        if (prev_rst[i]) begin
          checks++;
          if (status[i].done || status[i].sum != '0) begin
            $display("FAILED status[%0d] after rst_accs: done %h sum %h expected 0 and 0",
                     i, status[i].done, status[i].sum);
            errs++;
          end
        end
        if (status[i].done && !prev_done[i]) begin
          expected = expected_sum(cfg_base[i], cfg_count[i]);
          checks += 2;
          if (status[i].sum !== expected) begin
            $display("FAILED status[%0d].sum: got %h expected %h", i, status[i].sum, expected);
            errs++;
          end
          if (issued[i] != int'(cfg_count[i])) begin
            $display("FAILED requests of engine %0d: got %h expected %h",
                     i, issued[i], cfg_count[i]);
            errs++;
          end
        end
        if (start_accs[i]) issued[i] = 0;
        prev_done[i] = status[i].done;
      end
      prev_rst   = rst_accs;
      prev_avail = req_rd_available;

      if (test_done) begin
        tests++;
        if (errs == test_base) begin
          $display("Test %0d ok", test_num);
        end else begin
          $display("Test %0d has %0d errors", test_num, errs - test_base);
        end
        test_base = errs;
      end
      if (run_end) begin
        $display("%0d tests, %0d checks, %0d errors", tests, checks, errs);
      end
    end
    error_count <= errs;
  end

endmodule

`default_nettype wire

/* src/acc_management.sv */
`timescale 1ns/10ps
`default_nettype none

module acc_management (
  input  logic                              clk,
  input  logic                              rst_n,
  input  logic                              conf_valid,
  input  acc_pkg::conf_t                    conf,
  input  logic [acc_pkg::NUM_ENGINES-1:0]   start_accs,
  input  logic [acc_pkg::NUM_ENGINES-1:0]   rst_accs,
  input  logic                              req_rd_available,
  output logic                              req_rd_en,
  output acc_pkg::rd_req_t                  req_rd_req,
  input  logic                              resp_rd_valid,
  input  acc_pkg::rd_resp_t                 resp_rd,
  output acc_pkg::engine_status_t           status [acc_pkg::NUM_ENGINES]
);

  logic [acc_pkg::ADDR_W-1:0]       base  [acc_pkg::NUM_ENGINES];
  logic [acc_pkg::COUNT_W-1:0]      count [acc_pkg::NUM_ENGINES];
  logic [acc_pkg::NUM_ENGINES-1:0]  start;
  logic [acc_pkg::NUM_ENGINES-1:0]  grant;
  logic [acc_pkg::NUM_ENGINES-1:0]  req_pending;
  acc_pkg::rd_req_t                 req [acc_pkg::NUM_ENGINES];

  // ==================================================
  // Configuration
  // ==================================================

  conf_loader u_conf_loader (
    .clk        (clk),
    .rst_n      (rst_n),
    .conf_valid (conf_valid),
    .conf       (conf),
    .start_accs (start_accs),
    .base       (base),
    .count      (count),
    .start      (start)
  );

  // ==================================================
  // Engines
  // ==================================================

  for (genvar g = 0; g < acc_pkg::NUM_ENGINES; g++) begin : g_engine
    localparam logic [acc_pkg::ENGINE_ID_W-1:0] ID = g;   // Tag value of this engine.

    read_engine u_read_engine (
      .clk         (clk),
      .rst_n       (rst_n),
      .soft_rst    (rst_accs[g]),
      .engine_id   (ID),
      .start       (start[g]),
      .base        (base[g]),
      .count       (count[g]),
      .grant       (grant[g]),
      .req_pending (req_pending[g]),
      .req         (req[g]),
      .resp_valid  (resp_rd_valid),   // Broadcast to all engines.
      .resp        (resp_rd),
      .status      (status[g])
    );
  end

  // ==================================================
  // Read port arbitration
  // ==================================================

  req_arbiter u_req_arbiter (
    .clk              (clk),
    .rst_n            (rst_n),
    .req_pending      (req_pending),
    .req              (req),
    .req_rd_available (req_rd_available),
    .grant            (grant),
    .req_rd_en        (req_rd_en),
    .req_rd_req       (req_rd_req)
  );

endmodule

`default_nettype wire

/* src/req_arbiter.sv */
`timescale 1ns/10ps
`default_nettype none

module req_arbiter (
  input  logic                              clk,
  input  logic                              rst_n,
  input  logic [acc_pkg::NUM_ENGINES-1:0]   req_pending,
  input  acc_pkg::rd_req_t                  req [acc_pkg::NUM_ENGINES],
  input  logic                              req_rd_available,
  output logic [acc_pkg::NUM_ENGINES-1:0]   grant,
  output logic                              req_rd_en,
  output acc_pkg::rd_req_t                  req_rd_req
);

  logic [acc_pkg::ENGINE_ID_W-1:0]  last_served;
  logic [acc_pkg::ENGINE_ID_W-1:0]  sel_id;
  logic                             sel_valid;
  logic                             fire;

  // ==================================================
  // Round-robin pick
  // ==================================================

  // Search starts just after the last engine served.
  always_comb begin
    int cand;
    sel_id    = last_served;
    sel_valid = 1'b0;
    for (int off = 1; off <= acc_pkg::NUM_ENGINES; off++) begin
      cand = (int'(last_served) + off) % acc_pkg::NUM_ENGINES;
      if (!sel_valid && req_pending[cand]) begin
        sel_id    = cand[acc_pkg::ENGINE_ID_W-1:0];
        sel_valid = 1'b1;
      end
    end
  end

  assign fire = sel_valid && req_rd_available;   // Port must have room.

  always_comb begin
    for (int i = 0; i < acc_pkg::NUM_ENGINES; i++) begin
      grant[i] = fire && (int'(sel_id) == i);
    end
  end

  // ==================================================
  // Registered read port
  // ==================================================

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      last_served <= acc_pkg::ENGINE_ID_W'(acc_pkg::NUM_ENGINES - 1);   // Engine 0 first.
      req_rd_en   <= 1'b0;
    end else begin
      req_rd_en <= fire;
      if (fire) begin
        last_served <= sel_id;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (fire) begin
      req_rd_req <= req[sel_id];
    end
  end

  a_grant_onehot0 : assert property (
    @(posedge clk) disable iff (!rst_n)
    $onehot0(grant)
  ) else $error("req_arbiter: more than one grant");

endmodule

`default_nettype wire

/* src/read_engine.sv */
`timescale 1ns/10ps
`default_nettype none

module read_engine (
  input  logic                               clk,
  input  logic                               rst_n,
  input  logic                               soft_rst,
  input  logic [acc_pkg::ENGINE_ID_W-1:0]    engine_id,
  input  logic                               start,
  input  logic [acc_pkg::ADDR_W-1:0]         base,
  input  logic [acc_pkg::COUNT_W-1:0]        count,
  input  logic                               grant,
  output logic                               req_pending,
  output acc_pkg::rd_req_t                   req,
  input  logic                               resp_valid,
  input  acc_pkg::rd_resp_t                  resp,
  output acc_pkg::engine_status_t            status
);

  logic                             eng_rst;
  logic                             active;
  logic                             done;
  logic [acc_pkg::COUNT_W-1:0]      issue_cnt;
  logic [acc_pkg::COUNT_W-1:0]      recv_cnt;
  logic [acc_pkg::SUM_W-1:0]        sum;
  logic [acc_pkg::ENGINE_ID_W-1:0]  resp_tag;
  logic                             accept;

  assign eng_rst = !rst_n || soft_rst;   // Global or per-engine reset.

  // ==================================================
  // Request side
  // ==================================================

  assign req_pending = active && (issue_cnt != count);

  assign req.addr  = base + {{(acc_pkg::ADDR_W - acc_pkg::COUNT_W){1'b0}}, issue_cnt};
  assign req.mdata = {engine_id, {acc_pkg::TAG_PAD_W{1'b0}}, issue_cnt};

  // ==================================================
  // Response side
  // ==================================================

  assign resp_tag = resp.mdata[acc_pkg::MDATA_W-1 -: acc_pkg::ENGINE_ID_W];
  assign accept   = resp_valid && active && (resp_tag == engine_id);

  always_ff @(posedge clk) begin
    if (eng_rst) begin
      active    <= 1'b0;
      done      <= 1'b0;
      issue_cnt <= '0;
      recv_cnt  <= '0;
      sum       <= '0;
    end else if (start) begin
      active    <= 1'b1;   // New run, old result dropped.
      done      <= 1'b0;
      issue_cnt <= '0;
      recv_cnt  <= '0;
      sum       <= '0;
    end else begin
      if (grant) begin
        issue_cnt <= issue_cnt + 1'b1;   // Next address.
      end
      if (accept) begin
        sum      <= sum + {{(acc_pkg::SUM_W - acc_pkg::DATA_W){1'b0}}, resp.data};
        recv_cnt <= recv_cnt + 1'b1;
      end
      // Last sum update seen one cycle earlier.
      if (active && (recv_cnt == count)) begin
        done   <= 1'b1;
        active <= 1'b0;
      end
    end
  end

  assign status.done = done;
  assign status.sum  = sum;

  // The memory returns only what this engine asked for.
  a_resp_outstanding : assert property (
    @(posedge clk) disable iff (eng_rst)
    accept |-> (recv_cnt < issue_cnt)
  ) else $error("read_engine %0d: response with nothing outstanding", engine_id);

  // Arbiter grants only pending engines.
  a_grant_pending : assert property (
    @(posedge clk) disable iff (eng_rst)
    grant |-> req_pending
  ) else $error("read_engine %0d: grant without a pending request", engine_id);

endmodule

`default_nettype wire

/* src/conf_loader.sv */
`timescale 1ns/10ps
`default_nettype none

module conf_loader (
  input  logic                                     clk,
  input  logic                                     rst_n,
  input  logic                                     conf_valid,
  input  acc_pkg::conf_t                           conf,
  input  logic [acc_pkg::NUM_ENGINES-1:0]          start_accs,
  output logic [acc_pkg::ADDR_W-1:0]               base  [acc_pkg::NUM_ENGINES],
  output logic [acc_pkg::COUNT_W-1:0]              count [acc_pkg::NUM_ENGINES],
  output logic [acc_pkg::NUM_ENGINES-1:0]          start
);

  // ==================================================
  // Per-engine range registers
  // ==================================================

  // Only the addressed engine is written.
  always_ff @(posedge clk) begin
    if (conf_valid) begin
      base[conf.engine_id]  <= conf.base;
      count[conf.engine_id] <= conf.count;
    end
  end

  // ==================================================
  // Start strobes
  // ==================================================

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      start <= '0;
    end else begin
      start <= start_accs;   // One cycle behind the outside pulse.
    end
  end

  // A zero-length range would finish without reading anything.
  a_count_nonzero : assert property (
    @(posedge clk) disable iff (!rst_n)
    conf_valid |-> conf.count != '0
  ) else $error("conf_loader: zero count for engine %0d", conf.engine_id);

endmodule

`default_nettype wire

/* src/acc_pkg.sv */
`default_nettype none

package acc_pkg;

  // ==================================================
  // Sizes
  // ==================================================
  localparam int NUM_ENGINES = 4;
  localparam int ENGINE_ID_W = 2;
  localparam int ADDR_W      = 16;
  localparam int DATA_W      = 32;
  localparam int COUNT_W     = 8;   // Up to 255 words per run.
  localparam int SUM_W       = 40;
  localparam int MDATA_W     = 16;

  // Zero bits between the engine tag and the word index.
  localparam int TAG_PAD_W   = MDATA_W - ENGINE_ID_W - COUNT_W;

  // ==================================================
  // Shared records
  // ==================================================

  // One configuration word, 26 bits.
  typedef struct packed {
    logic [ENGINE_ID_W-1:0] engine_id;
    logic [ADDR_W-1:0]      base;
    logic [COUNT_W-1:0]     count;
  } conf_t;

  // mdata = {engine id, pad, word index}.
  typedef struct packed {
    logic [ADDR_W-1:0]  addr;
    logic [MDATA_W-1:0] mdata;
  } rd_req_t;

  typedef struct packed {
    logic [DATA_W-1:0]  data;
    logic [MDATA_W-1:0] mdata;   // Echo of the request tag.
  } rd_resp_t;

  typedef struct packed {
    logic             done;
    logic [SUM_W-1:0] sum;
  } engine_status_t;

endpackage

`default_nettype wire
